// File: flist.f
rtl/dino_pkg.sv
rtl/led_pkg.sv
rtl/tick_gen.sv
rtl/dino_ctrl.sv
rtl/obstacle_ctrl.sv
rtl/playfield_scan.sv
rtl/score_display.sv
rtl/dino_game_top.sv
tb/tb_dino_game.sv

// File: Bender.yml
package:
  name: dino_game

sources:
  - rtl/dino_pkg.sv
  - rtl/led_pkg.sv
  - rtl/tick_gen.sv
  - rtl/dino_ctrl.sv
  - rtl/obstacle_ctrl.sv
  - rtl/playfield_scan.sv
  - rtl/score_display.sv
  - rtl/dino_game_top.sv
  - target: test
    files:
      - tb/tb_dino_game.sv

// File: tb/tb_dino_game.sv
module tb_dino_game;

    localparam int frame_div = 4;
    localparam int scan_div  = 2;
    localparam int score_div = 64;

    // worst case from run start until the first cactus reaches the dino
    localparam int collision_limit =
        2 * (dino_pkg::START_DELAY_FRAMES + 32 * dino_pkg::STEP_FRAMES) * frame_div;

    localparam int cls_blank  = 0;
    localparam int cls_run    = 1;
    localparam int cls_jump   = 2;
    localparam int cls_crouch = 3;

    logic          clk;
    logic          rst;
    logic          jump_n;
    logic          crouch_n;
    led_pkg::row_t row;
    led_pkg::col_t col;
    led_pkg::seg_t hex0;
    led_pkg::seg_t hex1;
    led_pkg::seg_t hex2;
    led_pkg::seg_t hex3;
    led_pkg::seg_t hex4;
    led_pkg::seg_t hex5;

    // entries 6 and 7 follow the restart
    logic [1:0] tab_buttons [8] = '{2'b11, 2'b10, 2'b11, 2'b01, 2'b11, 2'b11, 2'b11, 2'b10};
    int         tab_hold    [8] = '{16, 24, 20, 8, 50, 90, 128, 20};
    int         tab_settle  [8] = '{0, 6, 6, 6, 0, 70, 0, 6};   // 70 covers the rest of the jump
    int         tab_class   [8] = '{cls_blank, cls_crouch, cls_run, cls_jump,
                                    cls_jump, cls_run, cls_blank, cls_crouch};

    logic [6:0] seg_code [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                  7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

    int       mismatches    = 0;
    int       failures      = 0;
    int       seed          = 58011;
    int       cur_class     = cls_blank;
    int       settle_left   = 0;
    bit       pose_check_on = 0;
    bit       score_clear_ok = 0;
    int       row_pos       = 0;
    logic [7:0] last_row    = 8'hFE;
    int       last_score    = 0;
    int       blank_run     = 0;    // row updates in a row with col at 0

    dino_game_top #(
        .frame_div(frame_div),
        .scan_div (scan_div),
        .score_div(score_div)
    ) uut (
        .clk, .rst, .jump_n, .crouch_n, .row, .col,
        .hex0, .hex1, .hex2, .hex3, .hex4, .hex5
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            mismatches++;
            $display("[ERROR] %0t %s: got 'h%0h, expected 'h%0h", $time, name, got, expected);
        end
    endtask

    function automatic logic [15:0] sprite_row(input int cls, input bit alt, input int r);
        logic [15:0] bits;
        bits = '0;
        case (cls)
            cls_run: begin
                case (r)
                    5:       bits = 16'h1800;
                    4:       bits = 16'h1400;
                    3:       bits = 16'h5800;
                    2:       bits = 16'h7800;
                    1:       bits = 16'h3000;
                    0:       bits = alt ? 16'h5000 : 16'h2800;   // legs
                    default: bits = '0;
                endcase
            end
            cls_jump: begin
                case (r)
                    7:       bits = 16'h4000;
                    6:       bits = 16'h2600;
                    5:       bits = 16'h3D00;
                    4:       bits = 16'h1E00;
                    3:       bits = alt ? 16'h2200 : 16'h1400;
                    default: bits = '0;
                endcase
            end
            cls_crouch: begin
                case (r)
                    3:       bits = 16'h4C00;
                    2:       bits = 16'h7E00;
                    1:       bits = 16'h3800;
                    0:       bits = alt ? 16'h4800 : 16'h2400;
                    default: bits = '0;
                endcase
            end
            default: bits = '0;
        endcase
        return bits;
    endfunction

    function automatic int seg_to_digit(input logic [6:0] code);
        for (int k = 0; k < 10; k++) begin
            if (code === seg_code[k]) return k;
        end
        return -1;
    endfunction

    // six digit value or -1 when a display shows no digit
    function automatic int read_score();
        logic [6:0] codes [6];
        int         value;
        int         d;
        codes = '{hex5, hex4, hex3, hex2, hex1, hex0};
        value = 0;
        for (int i = 0; i < 6; i++) begin
            d = seg_to_digit(codes[i]);
            if (d < 0) return -1;
            value = value * 10 + d;
        end
        return value;
    endfunction

    task automatic track_scan();
        logic [7:0]  exp_row;
        logic [15:0] exp_col;
        if (row === last_row) return;
        row_pos = (row_pos + 1) % 8;
        exp_row = ~(8'd1 << row_pos);
        check_equal("row", row, exp_row);
        last_row  = row;
        blank_run = (col == '0) ? blank_run + 1 : 0;
        if (!pose_check_on) return;
        if (settle_left > 0) begin
            settle_left--;
            return;
        end
        exp_col = sprite_row(cur_class, 1'b0, row_pos);
        if (col === sprite_row(cur_class, 1'b1, row_pos)) exp_col = col;   // b leg frame
        check_equal("col", col, exp_col);
    endtask

    task automatic track_score();
        int s;
        s = read_score();
        if (s == last_score) return;
        if (s < 0) begin
            failures++;
            $display("at %0t a score display shows a code that is not a decimal digit", $time);
        end else if (score_clear_ok && s == 0) begin
            score_clear_ok = 0;
        end else begin
            check_equal("score", s, (last_score + 1) % 1000000);
        end
        last_score = s;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            track_scan();
            track_score();
        end
    end

    task automatic apply_entries(input int first, input int last);
        int hold;
        for (int i = first; i <= last; i++) begin
            hold = tab_hold[i] + $urandom_range(tab_hold[i] / 8, 0);
            @(posedge clk);
            jump_n        <= tab_buttons[i][1];
            crouch_n      <= tab_buttons[i][0];
            cur_class     = tab_class[i];
            settle_left   = tab_settle[i];
            pose_check_on = 1;
            repeat (hold * scan_div - 1) @(posedge clk);
            @(negedge clk);
            if (tab_class[i] == cls_blank) check_equal("score", read_score(), 0);
        end
    endtask

    function automatic int watchdog_clocks();
        int total;
        total = collision_limit + 4 * score_div + 1000;
        for (int i = 0; i < 8; i++) begin
            total += (tab_hold[i] + tab_hold[i] / 8) * scan_div;
        end
        return total;
    endfunction

    task automatic finish_run();
        $display("checks done: %0d value mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    initial begin
        #(watchdog_clocks() * 10);
        failures++;
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int waited;
        int frozen;
        rst      = 1'b0;
        jump_n   = 1'b1;
        crouch_n = 1'b1;
        void'($urandom(seed));
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_equal("row", row, 8'hFE);
        check_equal("col", col, 16'h0000);
        check_equal("score", read_score(), 0);

        apply_entries(0, 5);
        pose_check_on = 0;

        // with no buttons the first cactus must hit the running dino
        waited = 0;
        while (blank_run < 8 && waited < collision_limit) begin
            @(posedge clk);
            waited++;
        end
        if (blank_run < 8) begin
            failures++;
            $display("no collision within %0d clock cycles of running", collision_limit);
        end else begin
            frozen = read_score();
            repeat (4 * score_div) begin
                @(negedge clk);
                check_equal("col", col, 16'h0000);
            end
            check_equal("score", read_score(), frozen);

            // one scan period of jump takes over back to idle without a new start
            score_clear_ok = 1;
            @(posedge clk);
            jump_n <= 1'b0;
            repeat (scan_div) @(posedge clk);
            jump_n <= 1'b1;
            apply_entries(6, 7);
            pose_check_on = 0;
        end
        finish_run();
    end

endmodule

// File: rtl/dino_game_top.sv
module dino_game_top #(
    parameter int frame_div = dino_pkg::FRAME_DIV,
    parameter int scan_div  = led_pkg::SCAN_DIV,
    parameter int score_div = led_pkg::SCORE_DIV
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          jump_n,
    input  logic          crouch_n,
    output led_pkg::row_t row,
    output led_pkg::col_t col,
    output led_pkg::seg_t hex0,
    output led_pkg::seg_t hex1,
    output led_pkg::seg_t hex2,
    output led_pkg::seg_t hex3,
    output led_pkg::seg_t hex4,
    output led_pkg::seg_t hex5
);

    logic                  frame_tick;
    logic                  scan_tick;
    logic                  score_tick;
    dino_pkg::pose_e       pose;
    dino_pkg::obs_x_t      obs_x;
    dino_pkg::shape_t      obs_shape;
    dino_pkg::game_state_e game_state;

    tick_gen #(.period(frame_div)) u_frame_tick (.clk, .rst, .en(1'b1), .tick(frame_tick));
    tick_gen #(.period(scan_div))  u_scan_tick  (.clk, .rst, .en(1'b1), .tick(scan_tick));

    // score timer only runs during play
    tick_gen #(.period(score_div)) u_score_tick (
        .clk, .rst, .en(game_state == dino_pkg::run), .tick(score_tick)
    );

    dino_ctrl u_dino (.clk, .rst, .frame_tick, .jump_n, .crouch_n, .pose);

    obstacle_ctrl u_obstacle (.clk, .rst, .frame_tick, .game_state, .obs_x, .obs_shape);

    playfield_scan u_scan (
        .clk, .rst, .scan_tick, .jump_n, .crouch_n, .pose, .obs_x, .obs_shape,
        .row, .col, .game_state
    );

    score_display u_score (
        .clk, .rst, .score_tick, .game_state,
        .hex0, .hex1, .hex2, .hex3, .hex4, .hex5
    );

endmodule

// File: rtl/score_display.sv
module score_display (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  score_tick,
    input  dino_pkg::game_state_e game_state,
    output led_pkg::seg_t         hex0,
    output led_pkg::seg_t         hex1,
    output led_pkg::seg_t         hex2,
    output led_pkg::seg_t         hex3,
    output led_pkg::seg_t         hex4,
    output led_pkg::seg_t         hex5
);

    led_pkg::bcd_t digit     [led_pkg::NUM_DIGITS];
    led_pkg::bcd_t digit_inc [led_pkg::NUM_DIGITS];

    // common anode, 0 lights a segment
    function automatic led_pkg::seg_t seg_decode(input led_pkg::bcd_t d);
        case (d)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;     // blank
        endcase
    endfunction

    // ripple carry, 999999 wraps to 0
    always_comb begin
        logic carry;
        carry = 1'b1;
        for (int i = 0; i < led_pkg::NUM_DIGITS; i++) begin
            digit_inc[i] = digit[i];
            if (carry) begin
                if (digit[i] == 4'd9) begin
                    digit_inc[i] = '0;
                end else begin
                    digit_inc[i] = digit[i] + 4'd1;
                    carry        = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            digit <= '{default: '0};
        end else if (game_state == dino_pkg::idle) begin
            digit <= '{default: '0};
        end else if (score_tick && game_state == dino_pkg::run) begin
            digit <= digit_inc;
        end
    end

    assign hex0 = seg_decode(digit[0]);
    assign hex1 = seg_decode(digit[1]);
    assign hex2 = seg_decode(digit[2]);
    assign hex3 = seg_decode(digit[3]);
    assign hex4 = seg_decode(digit[4]);
    assign hex5 = seg_decode(digit[5]);

endmodule

// File: rtl/playfield_scan.sv
module playfield_scan (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  scan_tick,
    input  logic                  jump_n,
    input  logic                  crouch_n,
    input  dino_pkg::pose_e       pose,
    input  dino_pkg::obs_x_t      obs_x,
    input  dino_pkg::shape_t      obs_shape,
    output led_pkg::row_t         row,
    output led_pkg::col_t         col,
    output dino_pkg::game_state_e game_state
);

    logic [2:0]    row_idx;
    logic [2:0]    next_row;
    led_pkg::col_t dino_row;
    led_pkg::col_t obs_row;
    logic [31:0]   obs_wide;
    led_pkg::col_t obs_vis;
    logic          hit;

    function automatic led_pkg::col_t dino_bits(input dino_pkg::pose_e p,
                                                input logic [2:0] r);
        led_pkg::col_t bits;
        logic          alt;
        bits = '0;
        alt  = (p == dino_pkg::run_b) || (p == dino_pkg::jump_b) ||
               (p == dino_pkg::crouch_b);
        case (p)
            dino_pkg::run_a, dino_pkg::run_b: begin
                case (r)
                    3'd5:    bits = 16'b0001_1000_0000_0000;
                    3'd4:    bits = 16'b0001_0100_0000_0000;
                    3'd3:    bits = 16'b0101_1000_0000_0000;
                    3'd2:    bits = 16'b0111_1000_0000_0000;
                    3'd1:    bits = 16'b0011_0000_0000_0000;
                    3'd0:    bits = alt ? 16'b0101_0000_0000_0000 : 16'b0010_1000_0000_0000;
                    default: bits = '0;
                endcase
            end
            dino_pkg::jump_a, dino_pkg::jump_b: begin   // raised by three rows
                case (r)
                    3'd7:    bits = 16'b0100_0000_0000_0000;
                    3'd6:    bits = 16'b0010_0110_0000_0000;
                    3'd5:    bits = 16'b0011_1101_0000_0000;
                    3'd4:    bits = 16'b0001_1110_0000_0000;
                    3'd3:    bits = alt ? 16'b0010_0010_0000_0000 : 16'b0001_0100_0000_0000;
                    default: bits = '0;
                endcase
            end
            dino_pkg::crouch_a, dino_pkg::crouch_b: begin
                case (r)
                    3'd3:    bits = 16'b0100_1100_0000_0000;
                    3'd2:    bits = 16'b0111_1110_0000_0000;
                    3'd1:    bits = 16'b0011_1000_0000_0000;
                    3'd0:    bits = alt ? 16'b0100_1000_0000_0000 : 16'b0010_0100_0000_0000;
                    default: bits = '0;
                endcase
            end
            default: bits = '0;
        endcase
        return bits;
    endfunction

    // unshifted obstacle sits in the low bits, off the visible half
    function automatic led_pkg::col_t obs_bits(input dino_pkg::shape_t s,
                                               input logic [2:0] r);
        led_pkg::col_t bits;
        bits = '0;
        if (!s) begin
            case (r)
                3'd2:    bits = 16'b0000_0000_0000_0101;
                3'd1:    bits = 16'b0000_0000_0000_1011;
                3'd0:    bits = 16'b0000_0000_0000_1001;
                default: bits = '0;
            endcase
        end else begin
            case (r)
                3'd7:    bits = 16'b0000_0000_0000_0010;
                3'd6:    bits = 16'b0000_0000_0000_0110;
                3'd5:    bits = 16'b0000_0000_0001_0111;
                3'd4:    bits = 16'b0000_0000_0000_1110;
                default: bits = '0;
            endcase
        end
        return bits;
    endfunction

    assign next_row = row_idx + 3'd1;
    assign dino_row = dino_bits(pose, next_row);
    assign obs_row  = obs_bits(obs_shape, next_row);
    assign obs_wide = {16'b0, obs_row} << obs_x;
    assign obs_vis  = obs_wide[31:16];
    assign hit      = |(dino_row & obs_vis);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            row_idx    <= '0;
            row        <= 8'hFE;
            col        <= '0;
            game_state <= dino_pkg::idle;
        end else if (scan_tick) begin
            row_idx <= next_row;
            row     <= ~(8'd1 << next_row);
            col     <= '0;
            case (game_state)
                dino_pkg::idle: if (!jump_n || !crouch_n) game_state <= dino_pkg::run;
                dino_pkg::run: begin
                    col <= dino_row | obs_vis;  // colliding row still shown
                    if (hit) game_state <= dino_pkg::over;
                end
                dino_pkg::over: if (!jump_n) game_state <= dino_pkg::idle;
                default:        game_state <= dino_pkg::idle;
            endcase
        end
    end

endmodule

// File: rtl/obstacle_ctrl.sv
module obstacle_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_tick,
    input  dino_pkg::game_state_e game_state,
    output dino_pkg::obs_x_t      obs_x,
    output dino_pkg::shape_t      obs_shape
);

    localparam int dw = $clog2(dino_pkg::START_DELAY_FRAMES);
    localparam int sw = $clog2(dino_pkg::STEP_FRAMES);

    logic [15:0]   lfsr;
    logic          feedback;
    logic [dw-1:0] delay_cnt;
    logic [sw-1:0] step_cnt;
    logic          moving;      // start delay done

    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // free running, so the shape depends on when the player starts
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lfsr <= dino_pkg::LFSR_SEED;
        end else if (frame_tick) begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            obs_x     <= '0;
            obs_shape <= 1'b0;
            delay_cnt <= '0;
            step_cnt  <= '0;
            moving    <= 1'b0;
        end else if (game_state == dino_pkg::idle) begin
            obs_x     <= '0;
            obs_shape <= 1'b0;
            delay_cnt <= '0;
            step_cnt  <= '0;
            moving    <= 1'b0;
        end else if (frame_tick && game_state == dino_pkg::run) begin
            if (!moving) begin
                if (delay_cnt == dw'(dino_pkg::START_DELAY_FRAMES - 1)) begin
                    delay_cnt <= '0;
                    moving    <= 1'b1;
                end else begin
                    delay_cnt <= delay_cnt + 1'b1;
                end
            end else if (step_cnt == sw'(dino_pkg::STEP_FRAMES - 1)) begin
                step_cnt <= '0;
                if (obs_x == 5'd31) begin
                    obs_x     <= '0;
                    obs_shape <= lfsr[15];  // new obstacle kind per pass
                end else begin
                    obs_x <= obs_x + 1'b1;
                end
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/dino_ctrl.sv
module dino_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            frame_tick,
    input  logic            jump_n,
    input  logic            crouch_n,
    output dino_pkg::pose_e pose
);

    typedef enum logic [1:0] {
        st_run,
        st_jump,
        st_crouch
    } mode_e;

    localparam int jw = $clog2(dino_pkg::JUMP_FRAMES);
    localparam int aw = $clog2(dino_pkg::ANIM_FRAMES);

    mode_e         mode;
    logic [jw-1:0] air_cnt;     // frames spent in the air
    logic [aw-1:0] anim_cnt;
    logic          leg;         // picks the b frame

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode     <= st_run;
            air_cnt  <= '0;
            anim_cnt <= '0;
            leg      <= 1'b0;
        end else if (frame_tick) begin
            if (anim_cnt == aw'(dino_pkg::ANIM_FRAMES - 1)) begin
                anim_cnt <= '0;
                leg      <= ~leg;
            end else begin
                anim_cnt <= anim_cnt + 1'b1;
            end

            case (mode)
                st_run: begin
                    if (!jump_n) begin
                        mode <= st_jump;
                    end else if (!crouch_n) begin
                        mode <= st_crouch;
                    end
                end
                st_jump: begin
                    if (air_cnt == jw'(dino_pkg::JUMP_FRAMES - 1)) begin
                        air_cnt <= '0;
                        mode    <= st_run;
                    end else begin
                        air_cnt <= air_cnt + 1'b1;
                    end
                end
                st_crouch: if (crouch_n) mode <= st_run;
                default:   mode <= st_run;
            endcase
        end
    end

    always_comb begin
        case (mode)
            st_jump:   pose = leg ? dino_pkg::jump_b : dino_pkg::jump_a;
            st_crouch: pose = leg ? dino_pkg::crouch_b : dino_pkg::crouch_a;
            default:   pose = leg ? dino_pkg::run_b : dino_pkg::run_a;
        endcase
    end

endmodule

// File: rtl/tick_gen.sv
module tick_gen #(
    parameter int period = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic tick
);

    localparam int cw = (period > 1) ? $clog2(period) : 1;

    logic [cw-1:0] count;

    assign tick = en && (count == cw'(period - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (!en || tick) begin
            count <= '0;    // restart on wrap or while disabled
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// File: rtl/led_pkg.sv
package led_pkg;

    typedef logic [7:0]  row_t;     // active low, one row at a time
    typedef logic [15:0] col_t;     // active high, bit 15 is the left edge
    typedef logic [6:0]  seg_t;     // active low, g down to a
    typedef logic [3:0]  bcd_t;

    localparam int NUM_DIGITS = 6;

    // defaults for a 50 MHz board clock
    localparam int SCAN_DIV  = 5000;
    localparam int SCORE_DIV = 5000000;     // 10 points per second

endpackage

// File: rtl/dino_pkg.sv
package dino_pkg;

    // game flow
    typedef enum logic [1:0] {
        idle,
        run,
        over
    } game_state_e;

    // sprite selection, a and b are the two leg frames
    typedef enum logic [2:0] {
        run_a,
        run_b,
        jump_a,
        jump_b,
        crouch_a,
        crouch_b
    } pose_e;

    typedef logic [4:0] obs_x_t;    // obstacle offset, visible from 16 up
    typedef logic       shape_t;    // 0 cactus, 1 bird

    localparam int FRAME_DIV = 833333;      // about 60 frames per second at 50 MHz

    localparam int JUMP_FRAMES        = 60;
    localparam int ANIM_FRAMES        = 11;
    localparam int START_DELAY_FRAMES = 120;
    localparam int STEP_FRAMES        = 6;

    localparam logic [15:0] LFSR_SEED = 16'hACE1;

endpackage
